/* verilog/dbg_defines.svh */
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// field widths
`define DBG_BYTE_W          8
`define DBG_ADDR_W          16
`define DBG_DATA_W          32
`define DBG_PC_W            16

// frame layout
`define DBG_FRAME_BYTES     12
`define DBG_SYNC_BYTES      3

// sync word, first byte on the link first
`define DBG_SYNC_2          8'h5A
`define DBG_SYNC_1          8'hA5
`define DBG_SYNC_0          8'h96

`define DBG_CRC_INIT        16'hFFFF

// cycles the cpu reset is held
`define DBG_CPU_RESET_LEN   4

// op + toggle + addr + data
`define DBG_PAYLOAD_W       56

`endif

/* verilog/dbg_pkg.sv */
`default_nettype none

`include "dbg_defines.svh"

package dbg_pkg;

    typedef enum logic [6:0] {
        OP_PRAM_WR_NOACK = 7'h01,
        OP_PRAM_WR_ACK   = 7'h02,
        OP_PRAM_RD       = 7'h03,
        OP_PAUSE_ON      = 7'h04,
        OP_PAUSE_OFF     = 7'h05,
        OP_BREAK_ON      = 7'h06,
        OP_BREAK_OFF     = 7'h07,
        OP_CPU_RESET     = 7'h08,
        OP_RUN_PULSE     = 7'h09,
        OP_READ_STATUS   = 7'h0A
    } dbg_op_e;

    typedef enum logic [3:0] {
        S_IDLE, S_SYNC_1, S_SYNC_0, S_COLLECT, S_LAST,
        S_CHECK, S_ACK, S_PRAM_WAIT, S_STATUS, S_WAIT_DONE
    } dbg_state_e;

    // type byte, address and data of one frame, MSB first on the link
    typedef struct packed {
        dbg_op_e                   op;
        logic                      toggle;
        logic [`DBG_ADDR_W-1:0]    addr;
        logic [`DBG_DATA_W-1:0]    data;
    } dbg_frame_t;

    // one-cycle strobes out of the FSM
    typedef struct packed {
        logic pram_wr;
        logic pram_rd;
        logic pause_on;
        logic pause_off;
        logic break_on;
        logic break_off;
        logic cpu_rst;
        logic run;
        logic rep_ack;
        logic rep_read;
        logic rep_status;
    } dbg_ctl_t;

    typedef enum logic [1:0] {
        REP_ACK, REP_READ_BACK, REP_STATUS
    } dbg_reply_e;

    // payload has the same field layout as a frame
    typedef struct packed {
        dbg_reply_e  kind;
        dbg_frame_t  payload;
    } dbg_reply_t;

endpackage

`default_nettype wire

/* verilog/dbg_crc16.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_crc16 (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      clear,
    input  wire                      en,
    input  wire [`DBG_BYTE_W-1:0]    data,
    output logic                     crc_ok
);

    logic [15:0] crc;

    // x^16 + x^12 + x^5 + 1, one byte MSB first
    function automatic logic [15:0] crc_byte(input logic [15:0] c, input logic [7:0] d);
        logic [15:0] r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            if (r[15] ^ d[i]) begin
                r = {r[14:0], 1'b0} ^ 16'h1021;
            end else begin
                r = {r[14:0], 1'b0};
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            crc <= `DBG_CRC_INIT;
        end else if (clear) begin
            crc <= `DBG_CRC_INIT;
        end else if (en) begin
            crc <= crc_byte(crc, data);
        end
    end

    // crc bytes appended MSB first leave a zero residue
    assign crc_ok = (crc == 16'h0000);

endmodule

`default_nettype wire

/* verilog/dbg_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_frame_rx (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      byte_valid,
    input  wire [`DBG_BYTE_W-1:0]    byte_data,
    input  wire                      cnt_clear,
    output logic                     byte_stb,
    output logic [`DBG_BYTE_W-1:0]   rx_byte,
    output logic [3:0]               byte_cnt,
    output dbg_pkg::dbg_frame_t      frame
);

    // sync bytes fall off the top, only type..crc are kept
    localparam int SR_W = (`DBG_FRAME_BYTES - `DBG_SYNC_BYTES) * `DBG_BYTE_W;

    logic [SR_W-1:0] frame_sr;

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            byte_stb <= 1'b0;
        end else begin
            byte_stb <= byte_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            frame_sr <= {frame_sr[SR_W-`DBG_BYTE_W-1:0], byte_data};
        end
    end

    assign rx_byte = frame_sr[`DBG_BYTE_W-1:0];

    ////////////////////////////////////////////////////////////////////
    // byte counter
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt <= 4'd0;
        end else if (cnt_clear) begin
            byte_cnt <= 4'd0;
        end else if (byte_stb) begin
            byte_cnt <= byte_cnt + 4'd1;
        end
    end

    // type, address and data sit above the two crc bytes
    assign frame = frame_sr[SR_W-1:2*`DBG_BYTE_W];

endmodule

`default_nettype wire

/* verilog/dbg_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_ctrl_fsm (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      byte_stb,
    input  wire [`DBG_BYTE_W-1:0]    rx_byte,
    input  wire [3:0]                byte_cnt,
    input  wire dbg_pkg::dbg_frame_t frame,
    input  wire                      crc_ok,
    input  wire                      pram_rd_valid,
    input  wire                      reply_done,
    output logic                     cnt_clear,
    output logic                     crc_clear,
    output dbg_pkg::dbg_ctl_t        ctl
);

    import dbg_pkg::*;

    // bytes counted in S_COLLECT before the last one
    localparam logic [3:0] LAST_CNT = 4'(`DBG_FRAME_BYTES - `DBG_SYNC_BYTES - 1);

    dbg_state_e state;
    dbg_state_e state_nxt;
    logic       rd_valid_q;

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state      <= S_IDLE;
            rd_valid_q <= 1'b0;
        end else begin
            state      <= state_nxt;
            rd_valid_q <= pram_rd_valid;
        end
    end

    assign cnt_clear = (state != S_COLLECT);

    always_comb begin
        state_nxt = state;
        crc_clear = 1'b0;
        ctl       = '0;

        case (state)
            S_IDLE: begin
                if (byte_stb && (rx_byte == `DBG_SYNC_2)) begin
                    state_nxt = S_SYNC_1;
                end else begin
                    crc_clear = 1'b1;
                end
            end

            S_SYNC_1: begin
                if (byte_stb) begin
                    state_nxt = (rx_byte == `DBG_SYNC_1) ? S_SYNC_0 : S_IDLE;
                end
            end

            S_SYNC_0: begin
                if (byte_stb) begin
                    state_nxt = (rx_byte == `DBG_SYNC_0) ? S_COLLECT : S_IDLE;
                end
            end

            S_COLLECT: begin
                if (byte_cnt == LAST_CNT) begin
                    state_nxt = S_LAST;
                end
            end

            // second crc byte
            S_LAST: begin
                if (byte_stb) begin
                    state_nxt = S_CHECK;
                end
            end

            ////////////////////////////////////////////////////////////
            // crc check and decode
            ////////////////////////////////////////////////////////////
            S_CHECK: begin
                state_nxt = S_IDLE;
                // crc back at init for a sync byte on the first idle cycle
                crc_clear = 1'b1;
                if (crc_ok) begin
                    case (frame.op)
                        OP_PRAM_WR_NOACK: ctl.pram_wr = 1'b1;
                        OP_PRAM_WR_ACK: begin
                            ctl.pram_wr = 1'b1;
                            state_nxt   = S_ACK;
                        end
                        OP_PRAM_RD: begin
                            ctl.pram_rd = 1'b1;
                            state_nxt   = S_PRAM_WAIT;
                        end
                        OP_PAUSE_ON: begin
                            ctl.pause_on = 1'b1;
                            state_nxt    = S_ACK;
                        end
                        OP_PAUSE_OFF: begin
                            ctl.pause_off = 1'b1;
                            state_nxt     = S_ACK;
                        end
                        OP_BREAK_ON: begin
                            ctl.break_on = 1'b1;
                            state_nxt    = S_ACK;
                        end
                        OP_BREAK_OFF: begin
                            ctl.break_off = 1'b1;
                            state_nxt     = S_ACK;
                        end
                        OP_CPU_RESET: begin
                            ctl.cpu_rst = 1'b1;
                            state_nxt   = S_ACK;
                        end
                        OP_RUN_PULSE: begin
                            ctl.run   = 1'b1;
                            state_nxt = S_ACK;
                        end
                        OP_READ_STATUS: state_nxt = S_STATUS;
                        default: state_nxt = S_IDLE;
                    endcase
                end
            end

            S_ACK: begin
                ctl.rep_ack = 1'b1;
                state_nxt   = S_WAIT_DONE;
            end

            S_STATUS: begin
                ctl.rep_status = 1'b1;
                state_nxt      = S_WAIT_DONE;
            end

            // reply block has the read data registered by now
            S_PRAM_WAIT: begin
                if (rd_valid_q) begin
                    ctl.rep_read = 1'b1;
                    state_nxt    = S_WAIT_DONE;
                end
            end

            // host bytes ignored here
            S_WAIT_DONE: begin
                crc_clear = 1'b1;
                if (reply_done) begin
                    state_nxt = S_IDLE;
                end
            end

            default: state_nxt = S_IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/dbg_cpu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_cpu_ctrl (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire dbg_pkg::dbg_ctl_t   ctl,
    input  wire dbg_pkg::dbg_frame_t frame,
    output logic                     pause,
    output logic                     break_on,
    output logic [`DBG_PC_W-1:0]     break_addr_a,
    output logic [`DBG_PC_W-1:0]     break_addr_b,
    output logic                     cpu_reset,
    output logic                     run_pulse
);

    logic [`DBG_CPU_RESET_LEN-1:0] rst_chain;

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            pause     <= 1'b0;
            break_on  <= 1'b0;
            rst_chain <= '0;
            cpu_reset <= 1'b0;
            run_pulse <= 1'b0;
        end else begin
            if (ctl.pause_on) begin
                pause <= 1'b1;
            end else if (ctl.pause_off) begin
                pause <= 1'b0;
            end
            if (ctl.break_on) begin
                break_on <= 1'b1;
            end else if (ctl.break_off) begin
                break_on <= 1'b0;
            end
            // one strobe walks the chain, reset held while any bit set
            rst_chain <= {rst_chain[`DBG_CPU_RESET_LEN-2:0], ctl.cpu_rst};
            cpu_reset <= |rst_chain;
            run_pulse <= ctl.run;
        end
    end

    // breakpoint pair from the address and data fields
    always_ff @(posedge clk) begin
        if (ctl.break_on) begin
            break_addr_a <= frame.addr[`DBG_PC_W-1:0];
            break_addr_b <= frame.data[`DBG_PC_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/dbg_pram_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_pram_port (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire dbg_pkg::dbg_ctl_t   ctl,
    input  wire dbg_pkg::dbg_frame_t frame,
    output logic                     pram_wr_en,
    output logic [`DBG_ADDR_W-3:0]   pram_wr_addr,
    output logic [`DBG_DATA_W-1:0]   pram_wr_data,
    output logic                     pram_rd_en,
    output logic [`DBG_ADDR_W-1:0]   pram_rd_addr
);

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            pram_wr_en <= 1'b0;
            pram_rd_en <= 1'b0;
        end else begin
            pram_wr_en <= ctl.pram_wr;
            pram_rd_en <= ctl.pram_rd;
        end
    end

    // writes are word addressed, reads keep the byte address
    always_ff @(posedge clk) begin
        if (ctl.pram_wr) begin
            pram_wr_addr <= frame.addr[`DBG_ADDR_W-1:2];
            pram_wr_data <= frame.data;
        end
        if (ctl.pram_rd) begin
            pram_rd_addr <= frame.addr;
        end
    end

endmodule

`default_nettype wire

/* verilog/dbg_reply.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_reply (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire dbg_pkg::dbg_ctl_t   ctl,
    input  wire dbg_pkg::dbg_frame_t frame,
    input  wire [`DBG_DATA_W-1:0]    pram_rd_data,
    input  wire [`DBG_PC_W-1:0]      cpu_pc,
    input  wire                      cpu_stall,
    output logic                     reply_valid,
    output dbg_pkg::dbg_reply_t      reply
);

    import dbg_pkg::*;

    logic [`DBG_DATA_W-1:0]     rd_data_q;
    dbg_reply_e                 kind;
    logic [`DBG_PAYLOAD_W-1:0]  payload;

    // read data is only valid for one cycle
    always_ff @(posedge clk) begin
        rd_data_q <= pram_rd_data;
    end

    always_comb begin
        kind    = REP_ACK;
        payload = {frame.op, frame.toggle, frame.addr, frame.data};
        if (ctl.rep_read) begin
            kind    = REP_READ_BACK;
            payload = {frame.op, frame.toggle, frame.addr, rd_data_q};
        end else if (ctl.rep_status) begin
            kind    = REP_STATUS;
            payload = {frame.op, frame.toggle, {(`DBG_ADDR_W-1){1'b0}}, cpu_stall,
                       {(`DBG_DATA_W-`DBG_PC_W){1'b0}}, cpu_pc};
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            reply_valid <= 1'b0;
        end else begin
            reply_valid <= ctl.rep_ack | ctl.rep_read | ctl.rep_status;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.rep_ack | ctl.rep_read | ctl.rep_status) begin
            reply.kind    <= kind;
            reply.payload <= payload;
        end
    end

endmodule

`default_nettype wire

/* verilog/dbg_coprocessor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_coprocessor (
    input  wire                      clk,
    input  wire                      reset_n,

    // host link
    input  wire                      byte_valid,
    input  wire [`DBG_BYTE_W-1:0]    byte_data,
    output dbg_pkg::dbg_reply_t      reply,
    output logic                     reply_valid,
    input  wire                      reply_done,

    // program ram
    output logic                     pram_wr_en,
    output logic [`DBG_ADDR_W-3:0]   pram_wr_addr,
    output logic [`DBG_DATA_W-1:0]   pram_wr_data,
    output logic                     pram_rd_en,
    output logic [`DBG_ADDR_W-1:0]   pram_rd_addr,
    input  wire                      pram_rd_valid,
    input  wire [`DBG_DATA_W-1:0]    pram_rd_data,

    // cpu
    input  wire [`DBG_PC_W-1:0]      cpu_pc,
    input  wire                      cpu_stall,
    output logic                     pause,
    output logic                     break_on,
    output logic [`DBG_PC_W-1:0]     break_addr_a,
    output logic [`DBG_PC_W-1:0]     break_addr_b,
    output logic                     cpu_reset,
    output logic                     run_pulse
);

    import dbg_pkg::*;

    logic                    byte_stb;
    logic [`DBG_BYTE_W-1:0]  rx_byte;
    logic [3:0]              byte_cnt;
    logic                    cnt_clear;
    logic                    crc_clear;
    logic                    crc_ok;
    dbg_frame_t              frame;
    dbg_ctl_t                ctl;

    ////////////////////////////////////////////////////////////////////
    // receive path
    ////////////////////////////////////////////////////////////////////

    dbg_frame_rx u_frame_rx (
        .clk, .reset_n, .byte_valid, .byte_data, .cnt_clear,
        .byte_stb, .rx_byte, .byte_cnt, .frame
    );

    dbg_crc16 u_crc16 (
        .clk, .reset_n,
        .clear  (crc_clear),
        .en     (byte_stb),
        .data   (rx_byte),
        .crc_ok (crc_ok)
    );

    dbg_ctrl_fsm u_ctrl_fsm (
        .clk, .reset_n, .byte_stb, .rx_byte, .byte_cnt, .frame, .crc_ok,
        .pram_rd_valid, .reply_done, .cnt_clear, .crc_clear, .ctl
    );

    ////////////////////////////////////////////////////////////////////
    // actions
    ////////////////////////////////////////////////////////////////////

    dbg_cpu_ctrl u_cpu_ctrl (
        .clk, .reset_n, .ctl, .frame, .pause, .break_on,
        .break_addr_a, .break_addr_b, .cpu_reset, .run_pulse
    );

    dbg_pram_port u_pram_port (
        .clk, .reset_n, .ctl, .frame, .pram_wr_en, .pram_wr_addr,
        .pram_wr_data, .pram_rd_en, .pram_rd_addr
    );

    dbg_reply u_reply (
        .clk, .reset_n, .ctl, .frame, .pram_rd_data, .cpu_pc, .cpu_stall,
        .reply_valid, .reply
    );

endmodule

`default_nettype wire

/* verif/dbg_coprocessor_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module dbg_coprocessor_assert (
    input wire clk,
    input wire reset_n,
    input wire cpu_reset,
    input wire run_pulse,
    input wire reply_valid,
    input wire pram_wr_en,
    input wire pram_rd_en,
    input wire pause,
    input wire break_on
);

    int fail_cnt = 0;

    // held for the full stretch, then released
    a_cpu_reset_len: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(cpu_reset) |-> cpu_reset [*`DBG_CPU_RESET_LEN] ##1 !cpu_reset)
        else begin
            fail_cnt++;
            $error("cpu_reset not held for exactly %0d cycles", `DBG_CPU_RESET_LEN);
        end

    a_reply_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        reply_valid |=> !reply_valid)
        else begin
            fail_cnt++;
            $error("reply_valid high for more than one cycle");
        end

    a_run_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        run_pulse |=> !run_pulse)
        else begin
            fail_cnt++;
            $error("run_pulse high for more than one cycle");
        end

    a_pram_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(pram_wr_en && pram_rd_en))
        else begin
            fail_cnt++;
            $error("program ram read and write requested together");
        end

    // first edge out of reset
    a_reset_levels: assert property (@(posedge clk)
        $rose(reset_n) |-> !(pause || break_on || cpu_reset || run_pulse ||
                             reply_valid || pram_wr_en || pram_rd_en))
        else begin
            fail_cnt++;
            $error("outputs not low after reset");
        end

endmodule

bind dbg_coprocessor dbg_coprocessor_assert u_assert (.*);

`default_nettype wire

/* verif/tb_dbg_coprocessor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defines.svh"

module tb_dbg_coprocessor;

    import dbg_pkg::*;

    localparam int         MAX_ROWS = 16;
    localparam logic [1:0] NO_REPLY = 2'd3;

    // expected reply kind in rep, effects are {wr, rd, rst, run, pause, brk}
    typedef struct packed {
        logic [6:0]  op;
        logic        toggle;
        logic [15:0] addr;
        logic [31:0] data;
        logic [1:0]  bad;
        logic [1:0]  rep;
        logic [5:0]  effects;
    } row_t;

    logic                      clk = 1'b0;
    logic                      reset_n;
    logic                      byte_valid;
    logic [`DBG_BYTE_W-1:0]    byte_data;
    dbg_reply_t                reply;
    logic                      reply_valid;
    logic                      reply_done;
    logic                      pram_wr_en;
    logic [`DBG_ADDR_W-3:0]    pram_wr_addr;
    logic [`DBG_DATA_W-1:0]    pram_wr_data;
    logic                      pram_rd_en;
    logic [`DBG_ADDR_W-1:0]    pram_rd_addr;
    logic                      pram_rd_valid;
    logic [`DBG_DATA_W-1:0]    pram_rd_data;
    logic [`DBG_PC_W-1:0]      cpu_pc;
    logic                      cpu_stall;
    logic                      pause;
    logic                      break_on;
    logic [`DBG_PC_W-1:0]      break_addr_a;
    logic [`DBG_PC_W-1:0]      break_addr_b;
    logic                      cpu_reset;
    logic                      run_pulse;

    row_t                      rows [0:MAX_ROWS-1];
    string                     names [0:MAX_ROWS-1];
    int                        n_rows;
    int                        errors;
    int                        failed;
    int                        wr_cnt;
    int                        rd_cnt;
    int                        rst_cnt;
    int                        run_cnt;
    int                        rep_cnt;
    logic [`DBG_ADDR_W-3:0]    cap_wr_addr;
    logic [`DBG_DATA_W-1:0]    cap_wr_data;
    logic [`DBG_ADDR_W-1:0]    cap_rd_addr;
    dbg_reply_t                cap_reply;
    logic [31:0]               mem [0:(1<<14)-1];
    logic [31:0]               rd_word;
    int                        rd_delay;
    integer                    seed = 32'haa24;

    dbg_coprocessor u_dut (.*);

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // program ram model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (pram_wr_en) begin
            mem[pram_wr_addr] <= pram_wr_data;
        end
    end

    // answers each read after a random number of cycles
    always begin
        @(posedge clk);
        if (pram_rd_en) begin
            rd_word  = mem[pram_rd_addr[`DBG_ADDR_W-1:2]];
            rd_delay = 1 + ($unsigned($random(seed)) % 6);
            repeat (rd_delay) @(posedge clk);
            #2;
            pram_rd_valid = 1'b1;
            pram_rd_data  = rd_word;
            @(posedge clk);
            #2;
            pram_rd_valid = 1'b0;
            pram_rd_data  = ~rd_word;
        end
    end

    // strobe counts and captured values of the current row
    always @(posedge clk) begin
        if (pram_wr_en) begin
            wr_cnt++;
            cap_wr_addr = pram_wr_addr;
            cap_wr_data = pram_wr_data;
        end
        if (pram_rd_en) begin
            rd_cnt++;
            cap_rd_addr = pram_rd_addr;
        end
        if (cpu_reset) begin
            rst_cnt++;
        end
        if (run_pulse) begin
            run_cnt++;
        end
        if (reply_valid) begin
            rep_cnt++;
            cap_reply = reply;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////////////////////////

    // x^16 + x^12 + x^5 + 1, byte at a time
    function automatic logic [15:0] ccitt_update(input logic [15:0] crc_in,
                                                 input logic [7:0] b);
        logic [15:0] c;
        c = crc_in ^ {b, 8'h00};
        for (int k = 0; k < 8; k++) begin
            c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
        end
        return c;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        byte_valid = 1'b1;
        byte_data  = b;
        @(posedge clk);
        #2;
        byte_valid = 1'b0;
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic send_frame(input row_t r);
        logic [7:0]  fb [0:11];
        logic [15:0] crc;
        fb[0] = `DBG_SYNC_2;
        fb[1] = r.bad[0] ? 8'h3C : `DBG_SYNC_1;
        fb[2] = `DBG_SYNC_0;
        fb[3] = {r.op, r.toggle};
        fb[4] = r.addr[15:8];
        fb[5] = r.addr[7:0];
        for (int i = 0; i < 4; i++) begin
            fb[6+i] = r.data[31-8*i -: 8];
        end
        crc = `DBG_CRC_INIT;
        for (int i = 0; i < 10; i++) begin
            crc = ccitt_update(crc, fb[i]);
        end
        fb[10] = crc[15:8];
        // bad crc flips the last bit on the link
        fb[11] = crc[7:0] ^ {7'd0, r.bad[1]};
        for (int i = 0; i < 12; i++) begin
            send_byte(fb[i]);
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            errors++;
            $display("Fail %s: %s expected %0h actual %0h", name, what, exp, act);
        end
    endtask

    task automatic add_row(input string nm, input logic [6:0] op, input logic tog,
                           input logic [15:0] addr, input logic [31:0] data,
                           input logic [1:0] bad, input int rep, input logic [5:0] eff);
        names[n_rows] = nm;
        rows[n_rows]  = {op, tog, addr, data, bad, rep[1:0], eff};
        n_rows++;
    endtask

    task automatic finish_test(input string nm, input int errs_before);
        if (errors != errs_before) begin
            failed++;
        end
        $display("%s: %s", nm, (errors == errs_before) ? "passed" : "failed");
    endtask

    task automatic check_row(input string nm, input row_t r);
        check_value(nm, "reply count", (r.rep != NO_REPLY), rep_cnt);
        if (r.rep != NO_REPLY && rep_cnt != 0) begin
            check_value(nm, "reply kind", r.rep, cap_reply.kind);
            check_value(nm, "reply op", r.op, cap_reply.payload.op);
            check_value(nm, "reply toggle", r.toggle, cap_reply.payload.toggle);
            case (r.rep)
                REP_READ_BACK: begin
                    check_value(nm, "reply addr", r.addr, cap_reply.payload.addr);
                    check_value(nm, "read data", mem[r.addr[15:2]], cap_reply.payload.data);
                end
                REP_STATUS: begin
                    check_value(nm, "status stall", {15'd0, cpu_stall}, cap_reply.payload.addr);
                    check_value(nm, "status pc", {16'd0, cpu_pc}, cap_reply.payload.data);
                end
                default: begin
                    check_value(nm, "reply addr", r.addr, cap_reply.payload.addr);
                    check_value(nm, "reply data", r.data, cap_reply.payload.data);
                end
            endcase
        end
        check_value(nm, "write strobes", r.effects[5], wr_cnt);
        if (r.effects[5]) begin
            check_value(nm, "write word addr", r.addr[15:2], cap_wr_addr);
            check_value(nm, "write data", r.data, cap_wr_data);
        end
        check_value(nm, "read strobes", r.effects[4], rd_cnt);
        if (r.effects[4]) begin
            check_value(nm, "read addr", r.addr, cap_rd_addr);
        end
        check_value(nm, "cpu reset cycles", r.effects[3] ? `DBG_CPU_RESET_LEN : 0, rst_cnt);
        check_value(nm, "run pulses", r.effects[2], run_cnt);
        check_value(nm, "pause", r.effects[1], pause);
        check_value(nm, "break_on", r.effects[0], break_on);
        if (r.effects[0] && r.op == OP_BREAK_ON) begin
            check_value(nm, "break_addr_a", r.addr[`DBG_PC_W-1:0], break_addr_a);
            check_value(nm, "break_addr_b", r.data[`DBG_PC_W-1:0], break_addr_b);
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   n;
        int   errs_before;
        r           = rows[idx];
        errs_before = errors;
        wr_cnt      = 0;
        rd_cnt      = 0;
        rst_cnt     = 0;
        run_cnt     = 0;
        rep_cnt     = 0;
        send_frame(r);
        n = 0;
        if (r.rep != NO_REPLY) begin
            while (rep_cnt == 0 && n < 60) begin
                @(posedge clk);
                #2;
                n++;
            end
            if (rep_cnt == 0) begin
                errors++;
                $display("%s: no reply arrived within 60 cycles", names[idx]);
            end else begin
                repeat (2) @(posedge clk);
                #2;
                reply_done = 1'b1;
                @(posedge clk);
                #2;
                reply_done = 1'b0;
            end
        end else begin
            // a reply here would be wrong, watch for one
            while (rep_cnt == 0 && n < 20) begin
                @(posedge clk);
                #2;
                n++;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        check_row(names[idx], r);
        // pulls the sync search back to idle after a broken frame
        send_byte(8'h00);
        repeat (4) @(posedge clk);
        #2;
        finish_test(names[idx], errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset_n       = 1'b0;
        byte_valid    = 1'b0;
        byte_data     = '0;
        reply_done    = 1'b0;
        pram_rd_valid = 1'b0;
        pram_rd_data  = '0;
        cpu_pc        = 16'hB3C4;
        cpu_stall     = 1'b1;
        errors        = 0;
        failed        = 0;
        n_rows        = 0;
        for (int i = 0; i < (1 << 14); i++) begin
            mem[i] = 32'h9E3779B9 * (i + 1);
        end

        // name, op, toggle, addr, data, bad {crc,sync}, reply (3 none), effects
        add_row("wr_ack", OP_PRAM_WR_ACK, 0, 16'h0124, 32'hDEADBEEF, 2'b00, 0, 6'b100000);
        add_row("wr_noack", OP_PRAM_WR_NOACK, 1, 16'h0200, 32'h12345678, 2'b00, 3, 6'b100000);
        add_row("rd_back", OP_PRAM_RD, 0, 16'h0124, 32'h0, 2'b00, 1, 6'b010000);
        add_row("rd_fill", OP_PRAM_RD, 1, 16'h0A08, 32'h0, 2'b00, 1, 6'b010000);
        add_row("pause_on", OP_PAUSE_ON, 0, 16'h0000, 32'h0, 2'b00, 0, 6'b000010);
        add_row("break_on", OP_BREAK_ON, 1, 16'h0340, 32'h00010588, 2'b00, 0, 6'b000011);
        add_row("break_off", OP_BREAK_OFF, 0, 16'h0000, 32'h0, 2'b00, 0, 6'b000010);
        add_row("pause_off", OP_PAUSE_OFF, 1, 16'h0000, 32'h0, 2'b00, 0, 6'b000000);
        add_row("cpu_reset", OP_CPU_RESET, 0, 16'h0000, 32'h0, 2'b00, 0, 6'b001000);
        add_row("run_pulse", OP_RUN_PULSE, 1, 16'h0000, 32'h0, 2'b00, 0, 6'b000100);
        add_row("status", OP_READ_STATUS, 0, 16'h0000, 32'h0, 2'b00, 2, 6'b000000);
        add_row("bad_crc", OP_PAUSE_ON, 0, 16'h0011, 32'h22, 2'b10, 3, 6'b000000);
        add_row("bad_sync", OP_BREAK_ON, 1, 16'h0777, 32'h00000999, 2'b01, 3, 6'b000000);
        add_row("bad_op", 7'h7F, 1, 16'h0000, 32'h0, 2'b00, 3, 6'b000000);
        add_row("wr_after_bad", OP_PRAM_WR_ACK, 1, 16'h0F0C, 32'hCAFE0123, 2'b00, 0, 6'b100000);

        repeat (8) @(posedge clk);
        #2;
        reset_n = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        check_value("reset", "output levels", 7'd0,
                    {pause, break_on, cpu_reset, run_pulse, reply_valid, pram_wr_en, pram_rd_en});
        finish_test("reset", 0);

        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end

        errors = errors + u_dut.u_assert.fail_cnt;
        $display("%0d tests, %0d failed, %0d errors", n_rows + 1, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/dbg_pkg.sv
verilog/dbg_crc16.sv
verilog/dbg_frame_rx.sv
verilog/dbg_ctrl_fsm.sv
verilog/dbg_cpu_ctrl.sv
verilog/dbg_pram_port.sv
verilog/dbg_reply.sv
verilog/dbg_coprocessor.sv
verif/dbg_coprocessor_assert.sv
verif/tb_dbg_coprocessor.sv
